/* Bender.yml */
package:
  name: multi_lane_accu

sources:
  - files:
      - hdl/accu_pkg.sv
      - hdl/lane_count_if.sv
      - hdl/lane_fifo.sv
      - hdl/lane_count_regs.sv
      - hdl/accu_sum.sv
      - hdl/accu_ctrl.sv
      - hdl/multi_lane_accu.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_multi_lane_accu.sv

/* hdl/accu_ctrl.sv */
`default_nettype none

module accu_ctrl (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 accu_en,
    output logic                 accu_finished,
    input  accu_pkg::lane_mask_t lane_valid,
    output accu_pkg::lane_mask_t pop,
    output logic                 flush,
    lane_count_if.ctrl           cnt,
    output logic                 sum_clear,
    input  logic                 sum_busy,
    input  accu_pkg::data_t      sum,
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output accu_pkg::data_t      m_tdata,
    output logic                 m_tlast
);
    import accu_pkg::*;

    accu_state_t state;
    accu_state_t state_nxt;
    logic        abort;       // job left, mid-way or after the result
    logic        hdr_ready;   // a header waits on every lane
    lane_mask_t  data_pop;

    assign abort     = !accu_en && (state != IDLE);
    assign hdr_ready = (lane_valid == '1);
    assign data_pop  = cnt.owing & lane_valid;   // may be empty

    assign flush     = abort;
    assign sum_clear = abort;

    assign accu_finished = (state == IDLE) || (state == FINISHED);

    ////////////////////////////////////////
    // lane pops and count strobes
    ////////////////////////////////////////

    always_comb begin
        pop      = '0;
        cnt.pop  = '0;
        cnt.load = 1'b0;
        if (accu_en) begin
            case (state)
                HEADER: begin
                    if (hdr_ready) begin
                        pop      = '1;        // headers are not summed
                        cnt.load = 1'b1;
                    end
                end
                GATHER: begin
                    pop     = data_pop;
                    cnt.pop = data_pop;       // also feeds the adder
                end
                default: begin
                    pop = '0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // job FSM
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        if (!accu_en) begin
            state_nxt = IDLE;
        end else begin
            case (state)
                IDLE:     state_nxt = HEADER;
                HEADER:   if (hdr_ready) state_nxt = GATHER;
                GATHER:   if (cnt.all_done) state_nxt = DRAIN;
                DRAIN:    if (!sum_busy) state_nxt = SEND;
                SEND:     if (m_tready) state_nxt = FINISHED;
                FINISHED: state_nxt = FINISHED;  // until accu_en falls
                default:  state_nxt = IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= IDLE;
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
        end else begin
            state    <= state_nxt;
            m_tvalid <= (state_nxt == SEND);  // held until accepted or aborted
            m_tlast  <= (state_nxt == SEND);  // the result is a single beat
        end
    end

    // result captured once, stable for the whole SEND
    always_ff @(posedge sys_clk) begin
        if ((state == DRAIN) && (state_nxt == SEND)) begin
            m_tdata <= sum;
        end
    end

endmodule

`default_nettype wire

/* hdl/accu_pkg.sv */
`default_nettype none

package accu_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int NUM_LANES  = 4;   // input streams
    localparam int DATA_W     = 64;  // word and sum width
    localparam int LEN_W      = 16;  // header count bits, low end of the header word
    localparam int FIFO_DEPTH = 8;   // default lane buffer depth

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]         len_t;
    typedef logic [NUM_LANES-1:0]     lane_mask_t;  // one bit per lane

    // head words of all lane FIFOs
    typedef data_t lane_data_t [NUM_LANES];

    // job sequence of the controller
    typedef enum logic [2:0] {
        IDLE,      // waiting for accu_en
        HEADER,    // waiting for one header word on every lane
        GATHER,    // popping data words
        DRAIN,     // adder pipeline emptying
        SEND,      // result beat on the output
        FINISHED   // result taken, waiting for accu_en low
    } accu_state_t;

endpackage

`default_nettype wire

/* hdl/accu_sum.sv */
`default_nettype none

module accu_sum (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  accu_pkg::lane_mask_t add,
    input  accu_pkg::lane_data_t head,
    input  logic                 clear,
    output logic                 busy,
    output accu_pkg::data_t      sum
);
    import accu_pkg::*;

    data_t part_nxt;   // masked sum of the head words
    data_t part_q;     // stage 1 result
    logic  part_vld;   // stage 1 holds a pending add

    ////////////////////////////////////////
    // stage 1
    ////////////////////////////////////////

    always_comb begin
        part_nxt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (add[i]) begin
                part_nxt = part_nxt + head[i];  // wraps mod 2^64
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        part_q <= part_nxt;
    end

    ////////////////////////////////////////
    // stage 2, running sum
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            part_vld <= 1'b0;
            sum      <= '0;
        end else if (clear) begin
            part_vld <= 1'b0;      // pending add is discarded
            sum      <= '0;
        end else begin
            part_vld <= (add != '0);
            if (part_vld) begin
                sum <= sum + part_q;
            end
        end
    end

    // a pop at the input or a partial sum still on its way
    assign busy = part_vld || (add != '0);

endmodule

`default_nettype wire

/* hdl/lane_count_if.sv */
`default_nettype none

interface lane_count_if ();
    import accu_pkg::*;

    logic       load;      // capture header counts
    lane_mask_t pop;       // one data word taken per set bit
    lane_mask_t owing;     // lane still has words to deliver
    logic       all_done;  // nothing owed on any lane

    modport ctrl (
        output load,
        output pop,
        input  owing,
        input  all_done
    );

    modport regs (
        input  load,
        input  pop,
        output owing,
        output all_done
    );

endinterface

`default_nettype wire

/* hdl/lane_count_regs.sv */
`default_nettype none

module lane_count_regs (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  accu_pkg::lane_data_t head,
    lane_count_if.regs           cnt
);
    import accu_pkg::*;

    len_t       hdr_cnt [NUM_LANES];  // words announced by the header
    len_t       dlv_cnt [NUM_LANES];  // words popped so far
    lane_mask_t owing;

    ////////////////////////////////////////
    // per-lane counters
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                hdr_cnt[i] <= '0;
                dlv_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (cnt.load) begin
                    hdr_cnt[i] <= head[i][LEN_W-1:0];  // upper header bits ignored
                    dlv_cnt[i] <= '0;
                end else if (cnt.pop[i]) begin
                    dlv_cnt[i] <= dlv_cnt[i] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // status back to the controller
    ////////////////////////////////////////

    // a zero count never owes anything
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            owing[i] = (dlv_cnt[i] < hdr_cnt[i]);
        end
    end

    assign cnt.owing    = owing;
    assign cnt.all_done = (owing == '0);

endmodule

`default_nettype wire

/* hdl/lane_fifo.sv */
`default_nettype none

module lane_fifo #(
    parameter int DEPTH = accu_pkg::FIFO_DEPTH
) (
    input  logic            sys_clk,
    input  logic            sys_rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  accu_pkg::data_t in_data,
    output logic            out_valid,
    output accu_pkg::data_t out_data,
    input  logic            pop,
    input  logic            flush
);
    import accu_pkg::*;

    data_t                        mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;     // words held
    logic                         push;
    logic                         take;

    assign in_ready  = (count != DEPTH);    // low only when full
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];         // head word

    assign push = in_valid && in_ready && !flush;
    assign take = pop && out_valid && !flush;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;            // drop everything in one cycle
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == DEPTH - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (take) begin
                if (rd_ptr == DEPTH - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/multi_lane_accu.sv */
`default_nettype none

module multi_lane_accu (
    input  logic            sys_clk,
    input  logic            sys_rst_n,
    input  logic            accu_en,
    output logic            accu_finished,
    input  logic            s0_tvalid,
    output logic            s0_tready,
    input  accu_pkg::data_t s0_tdata,
    input  logic            s1_tvalid,
    output logic            s1_tready,
    input  accu_pkg::data_t s1_tdata,
    input  logic            s2_tvalid,
    output logic            s2_tready,
    input  accu_pkg::data_t s2_tdata,
    input  logic            s3_tvalid,
    output logic            s3_tready,
    input  accu_pkg::data_t s3_tdata,
    output logic            m_tvalid,
    input  logic            m_tready,
    output accu_pkg::data_t m_tdata,
    output logic            m_tlast
);
    import accu_pkg::*;

    wire lane_mask_t lane_valid;   // head word present, per lane
    lane_mask_t      fifo_pop;     // header and data pops
    lane_data_t      lane_head;
    logic            flush;
    logic            sum_clear;
    logic            sum_busy;
    data_t           sum;

    lane_count_if cnt_bus ();

    ////////////////////////////////////////
    // input lanes
    ////////////////////////////////////////

    lane_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (s0_tvalid),
        .in_ready  (s0_tready),
        .in_data   (s0_tdata),
        .out_valid (lane_valid[0]),
        .out_data  (lane_head[0]),
        .pop       (fifo_pop[0]),
        .flush     (flush)
    );

    lane_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo1 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (s1_tvalid),
        .in_ready  (s1_tready),
        .in_data   (s1_tdata),
        .out_valid (lane_valid[1]),
        .out_data  (lane_head[1]),
        .pop       (fifo_pop[1]),
        .flush     (flush)
    );

    lane_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo2 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (s2_tvalid),
        .in_ready  (s2_tready),
        .in_data   (s2_tdata),
        .out_valid (lane_valid[2]),
        .out_data  (lane_head[2]),
        .pop       (fifo_pop[2]),
        .flush     (flush)
    );

    lane_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo3 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (s3_tvalid),
        .in_ready  (s3_tready),
        .in_data   (s3_tdata),
        .out_valid (lane_valid[3]),
        .out_data  (lane_head[3]),
        .pop       (fifo_pop[3]),
        .flush     (flush)
    );

    ////////////////////////////////////////
    // core
    ////////////////////////////////////////

    lane_count_regs u_regs (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .head      (lane_head),
        .cnt       (cnt_bus.regs)
    );

    accu_sum u_sum (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .add       (cnt_bus.pop),      // data pops only
        .head      (lane_head),
        .clear     (sum_clear),
        .busy      (sum_busy),
        .sum       (sum)
    );

    accu_ctrl u_ctrl (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .accu_en       (accu_en),
        .accu_finished (accu_finished),
        .lane_valid    (lane_valid),
        .pop           (fifo_pop),
        .flush         (flush),
        .cnt           (cnt_bus.ctrl),
        .sum_clear     (sum_clear),
        .sum_busy      (sum_busy),
        .sum           (sum),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tdata       (m_tdata),
        .m_tlast       (m_tlast)
    );

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hdl/accu_pkg.sv
hdl/lane_count_if.sv
hdl/lane_fifo.sv
hdl/lane_count_regs.sv
hdl/accu_sum.sv
hdl/accu_ctrl.sv
hdl/multi_lane_accu.sv
testbench/tb_multi_lane_accu.sv

/* include/tb_accu_checks.svh */
`ifndef TB_ACCU_CHECKS_SVH
`define TB_ACCU_CHECKS_SVH

// galois form with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
endfunction

// one lfsr step per bit taken with the lsb shifted out first
function automatic logic [63:0] lfsr_take(inout logic [31:0] state, input int nbits);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
        val   = {val[62:0], state[0]};
        state = lfsr_step(state);
    end
    return val;
endfunction

task automatic check_data(input string what, input accu_pkg::data_t got,
                          input accu_pkg::data_t exp);
    if (got !== exp) begin
        $display("%s: got %h, expected %h", what, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "data mismatch");
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("%s: got %h, expected %h", what, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "flag mismatch");
    end
endtask

`endif

/* testbench/tb_multi_lane_accu.sv */
`default_nettype none

module tb_multi_lane_accu;
    import accu_pkg::*;

    `include "tb_accu_checks.svh"

    localparam int MAX_CNT     = 12;                  // largest header count drawn
    localparam int NUM_JOBS    = 12;
    localparam int CYCLE_LIMIT = 200 * NUM_JOBS + 100;

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic                 accu_en;
    logic                 accu_finished;
    logic [NUM_LANES-1:0] s_tvalid;
    wire  [NUM_LANES-1:0] s_tready;
    data_t                s_tdata [NUM_LANES];
    logic                 m_tvalid;
    logic                 m_tready;
    data_t                m_tdata;
    logic                 m_tlast;

    logic [31:0] lfsr;                                // random source
    data_t       lane_words [NUM_LANES][MAX_CNT+1];  // header, then data words
    int          lane_len [NUM_LANES];
    int          lane_idx [NUM_LANES];               // next word to offer
    logic        lane_taken [NUM_LANES];             // handshake at the coming edge
    int          cycle_cnt = 0;

    multi_lane_accu uut (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .accu_en       (accu_en),
        .accu_finished (accu_finished),
        .s0_tvalid     (s_tvalid[0]),
        .s0_tready     (s_tready[0]),
        .s0_tdata      (s_tdata[0]),
        .s1_tvalid     (s_tvalid[1]),
        .s1_tready     (s_tready[1]),
        .s1_tdata      (s_tdata[1]),
        .s2_tvalid     (s_tvalid[2]),
        .s2_tready     (s_tready[2]),
        .s2_tdata      (s_tdata[2]),
        .s3_tvalid     (s_tvalid[3]),
        .s3_tready     (s_tready[3]),
        .s3_tdata      (s_tdata[3]),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tdata       (m_tdata),
        .m_tlast       (m_tlast)
    );

    ////////////////////////////////////////
    // clock and run limit
    ////////////////////////////////////////

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: no end of the run after %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // lane stimulus
    ////////////////////////////////////////

    // mid-cycle look at the lane handshakes
    task automatic observe_lanes();
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_taken[l] = s_tvalid[l] && s_tready[l];
            if (lane_taken[l]) begin
                lane_idx[l]++;
            end
        end
    endtask

    // valid stays up until taken, random gaps otherwise
    task automatic drive_lanes();
        logic [63:0] rnd;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (lane_idx[l] >= lane_len[l]) begin
                s_tvalid[l] = 1'b0;
            end else if (!(s_tvalid[l] && !lane_taken[l])) begin
                rnd         = lfsr_take(lfsr, 2);
                s_tvalid[l] = (rnd[1:0] != 2'b00);   // about 3 in 4
                s_tdata[l]  = lane_words[l][lane_idx[l]];
            end
            lane_taken[l] = 1'b0;
        end
        rnd      = lfsr_take(lfsr, 1);
        m_tready = rnd[0];
    endtask

    ////////////////////////////////////////
    // one job
    ////////////////////////////////////////

    task automatic run_job(input bit all_zero, input bit abort_mid);
        len_t        cnt [NUM_LANES];
        data_t       model_sum;
        logic [63:0] rnd;
        bit          accepted;
        bit          hold;
        int          cyc;
        model_sum = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            rnd    = lfsr_take(lfsr, 4);
            cnt[l] = all_zero ? len_t'(0) : len_t'(rnd % (MAX_CNT + 1));
            if (abort_mid && l == 0) begin
                cnt[l] = len_t'(MAX_CNT);           // cannot finish before the abort
            end
            rnd              = lfsr_take(lfsr, 48);
            lane_words[l][0] = {rnd[47:0], cnt[l]};  // upper header bits are noise
            for (int k = 1; k <= cnt[l]; k++) begin
                rnd              = lfsr_take(lfsr, 64);
                lane_words[l][k] = data_t'(rnd);
                model_sum        = model_sum + data_t'(rnd);  // wraps mod 2^64
            end
            lane_len[l]   = cnt[l] + 1;
            lane_idx[l]   = 0;
            lane_taken[l] = 1'b0;
        end

        accu_en = 1'b1;
        drive_lanes();
        accepted = 1'b0;
        hold     = 1'b0;
        cyc      = 0;
        while (!accepted && !(abort_mid && cyc == 6)) begin
            @(negedge sys_clk);
            observe_lanes();
            // still IDLE on the first look
            check_flag("FAILED accu_finished", accu_finished, (cyc == 0));
            if (abort_mid) begin
                check_flag("FAILED m_tvalid", m_tvalid, 1'b0);
            end
            if (hold) begin
                check_flag("FAILED m_tvalid", m_tvalid, 1'b1);
            end
            // a held beat keeps the model sum on every cycle
            if (m_tvalid) begin
                check_data("FAILED m_tdata", m_tdata, model_sum);
                check_flag("FAILED m_tlast", m_tlast, 1'b1);
                accepted = m_tready;
                hold     = !m_tready;
            end
            @(posedge sys_clk);
            #2;
            cyc++;
            drive_lanes();
        end

        if (!abort_mid) begin
            // result taken, FINISHED until accu_en falls
            repeat (3) begin
                @(negedge sys_clk);
                check_flag("FAILED accu_finished", accu_finished, 1'b1);
                check_flag("FAILED m_tvalid", m_tvalid, 1'b0);
                @(posedge sys_clk);
                #2;
            end
        end

        accu_en  = 1'b0;
        s_tvalid = '0;
        @(negedge sys_clk);
        check_flag("FAILED m_tvalid", m_tvalid, 1'b0);
        @(posedge sys_clk);
        #2;
        @(negedge sys_clk);
        check_flag("FAILED accu_finished", accu_finished, 1'b1);  // back in IDLE
        check_flag("FAILED m_tvalid", m_tvalid, 1'b0);
        @(posedge sys_clk);
        #2;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        sys_rst_n = 1'b0;
        accu_en   = 1'b0;
        m_tready  = 1'b0;
        s_tvalid  = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            s_tdata[l] = '0;
        end
        lfsr = 32'd88;
        repeat (5) @(posedge sys_clk);
        #2;
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        check_flag("FAILED accu_finished", accu_finished, 1'b1);
        check_flag("FAILED m_tvalid", m_tvalid, 1'b0);
        @(posedge sys_clk);
        #2;
        // job 1 has empty lanes, jobs 4 and 9 are dropped half way
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job((j == 1), (j == 4) || (j == 9));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
